// ==== source/afu_stream_cfg.svh ====
/*
 * Configuration macros for the cacheline streaming engine:
 * address and line widths, line buffer depth and the
 * bit positions of the fields in the software context word
 */
`ifndef AFU_STREAM_CFG_SVH
`define AFU_STREAM_CFG_SVH

// cacheline address, byte offset bits dropped
`define AFU_ADDR_W 58
`define AFU_CL_W 512

// line buffer holds 2**3 lines, which is also the read batch limit
`define AFU_BUF_DEPTH_BITS 3

// context fields are 64-bit byte addresses, keep the cacheline part
`define AFU_IMAGE_END_LSB 262
`define AFU_OUTPUT_END_LSB 326

`endif

// ==== source/afu_stream_pkg.sv ====
/*
 * Shared types of the streaming engine: vector typedefs,
 * the decoded context and request structs, and the
 * read and write state encodings
 */
`include "afu_stream_cfg.svh"

package afu_stream_pkg;

  typedef logic [`AFU_ADDR_W-1:0] cl_addr_t;
  typedef logic [`AFU_CL_W-1:0] cacheline_t;
  typedef logic [`AFU_CL_W-1:0] context_t;

  // one extra bit so a full batch can be counted
  typedef logic [`AFU_BUF_DEPTH_BITS:0] batch_count_t;

  typedef struct packed {
    cl_addr_t image_end;
    cl_addr_t output_end;
  } afu_ctx_t;

  typedef struct packed {
    cl_addr_t addr;
  } rd_req_t;

  typedef struct packed {
    cl_addr_t addr;
    cacheline_t data;
  } wr_req_t;

  typedef enum logic [1:0] {RD_IDLE, RD_PREPARE, RD_ISSUE, RD_DONE} rd_state_t;

  typedef enum logic [1:0] {WR_DATA, WR_WAIT, WR_FENCE, WR_FLAG} wr_state_t;

endpackage

// ==== source/line_counters.sv ====
/*
 * Read and output address counters shared by the read
 * and write state machines
 */
`include "afu_stream_cfg.svh"

module line_counters (
  input  logic                     clk,
  input  logic                     reset,
  // one pulse per read request issued
  input  logic                     rd_req_en,
  // one pulse per data write only, never for a flag write
  input  logic                     wr_req_en,
  output afu_stream_pkg::cl_addr_t rd_addr,
  output afu_stream_pkg::cl_addr_t wr_addr
);

  // next cacheline to fetch from the source buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_addr <= '0;
    end else if (rd_req_en) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  // next output line
  // line 0 is kept for the completion flag so data starts at 1
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_addr <= `AFU_ADDR_W'(1);
    end else if (wr_req_en) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

endmodule

// ==== source/read_req_fsm.sv ====
/*
 * Context capture and batched read request state machine:
 * latches the end addresses on start, then issues reads in
 * batches of at most one line buffer depth
 */
`include "afu_stream_cfg.svh"

module read_req_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  afu_stream_pkg::context_t afu_context,
  input  logic                     rd_req_almostfull,
  input  afu_stream_pkg::cl_addr_t rd_addr,
  input  afu_stream_pkg::cl_addr_t wr_addr,
  output afu_stream_pkg::rd_req_t  rd_req,
  output logic                     rd_req_en,
  output afu_stream_pkg::afu_ctx_t ctx
);

  import afu_stream_pkg::*;

  rd_state_t    state;
  batch_count_t batch_count;
  cl_addr_t     next_addr;
  logic         batch_full;
  logic         lines_left;

  // the counter advances one edge after the strobe,
  // so add the request still in flight
  assign next_addr = rd_addr + cl_addr_t'(rd_req_en);

  // MSB set means 2**depth_bits lines issued in this batch
  assign batch_full = batch_count[`AFU_BUF_DEPTH_BITS];
  assign lines_left = (next_addr < ctx.image_end);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= RD_IDLE;
      rd_req_en   <= 1'b0;
      batch_count <= '0;
      ctx         <= '0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (start) begin
            ctx.image_end  <= afu_context[`AFU_IMAGE_END_LSB +: `AFU_ADDR_W];
            ctx.output_end <= afu_context[`AFU_OUTPUT_END_LSB +: `AFU_ADDR_W];
            state          <= RD_PREPARE;
          end
        end

        RD_PREPARE: begin
          if (rd_addr == ctx.image_end) begin
            state <= RD_DONE;
          end else if (wr_addr == rd_addr + 1'b1) begin
            // previous batch fully written back, buffer is free again
            batch_count <= '0;
            state       <= RD_ISSUE;
          end
        end

        RD_ISSUE: begin
          if (rd_req_almostfull) begin
            rd_req_en <= 1'b0;
          end else if (lines_left && !batch_full) begin
            rd_req_en   <= 1'b1;
            batch_count <= batch_count + 1'b1;
          end else begin
            rd_req_en <= 1'b0;
            state     <= RD_PREPARE;
          end
        end

        // single run per reset
        RD_DONE: begin
          rd_req_en <= 1'b0;
        end

        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

  // request address follows the issue condition
  always_ff @(posedge clk) begin
    if (state == RD_ISSUE && !rd_req_almostfull && lines_left && !batch_full) begin
      rd_req.addr <= next_addr;
    end
  end

endmodule

// ==== source/line_fifo.sv ====
/*
 * Read response capture register followed by a circular
 * cacheline buffer with head-of-queue read
 */
`include "afu_stream_cfg.svh"

module line_fifo (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       rd_rsp_valid,
  input  afu_stream_pkg::cacheline_t rd_rsp_data,
  input  logic                       pop,
  output afu_stream_pkg::cacheline_t dout,
  output logic                       empty
);

  import afu_stream_pkg::*;

  // response stage
  logic       rsp_valid_q;
  cacheline_t rsp_data_q;

  // buffer storage and pointers, extra MSB tells full from empty
  cacheline_t                   mem [0:(1 << `AFU_BUF_DEPTH_BITS)-1];
  logic [`AFU_BUF_DEPTH_BITS:0] wr_ptr;
  logic [`AFU_BUF_DEPTH_BITS:0] rd_ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= rd_rsp_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_data_q <= rd_rsp_data;
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_q) begin
      mem[wr_ptr[`AFU_BUF_DEPTH_BITS-1:0]] <= rsp_data_q;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (rsp_valid_q) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // head entry is visible before the pop
  assign dout  = mem[rd_ptr[`AFU_BUF_DEPTH_BITS-1:0]];
  assign empty = (wr_ptr == rd_ptr);

endmodule

// ==== source/write_req_fsm.sv ====
/*
 * Write request state machine: pops a buffered line, writes it
 * to the next output address, issues a fence, then writes the
 * flag line at address 0 and tracks the done level
 */

module write_req_fsm (
  input  logic                       clk,
  input  logic                       reset,
  input  afu_stream_pkg::afu_ctx_t   ctx,
  input  logic                       wr_req_almostfull,
  input  logic                       empty,
  input  afu_stream_pkg::cacheline_t dout,
  input  afu_stream_pkg::cl_addr_t   wr_addr,
  output logic                       pop,
  output afu_stream_pkg::wr_req_t    wr_req,
  output logic                       wr_req_en,
  output logic                       data_wr,
  output logic                       wr_fence_valid,
  output logic                       done
);

  import afu_stream_pkg::*;

  wr_state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state          <= WR_DATA;
      pop            <= 1'b0;
      wr_req_en      <= 1'b0;
      data_wr        <= 1'b0;
      wr_fence_valid <= 1'b0;
      done           <= 1'b0;
    end else begin
      case (state)
        WR_DATA: begin
          wr_req_en <= 1'b0;
          done      <= (wr_addr == ctx.output_end);
          if (!wr_req_almostfull && !empty) begin
            pop   <= 1'b1;
            state <= WR_WAIT;
          end
        end

        // head line is taken on the pop edge, the write waits for credit
        WR_WAIT: begin
          pop <= 1'b0;
          if (!wr_req_almostfull) begin
            wr_req_en <= 1'b1;
            data_wr   <= 1'b1;
            state     <= WR_FENCE;
          end
        end

        WR_FENCE: begin
          wr_req_en <= 1'b0;
          data_wr   <= 1'b0;
          if (!wr_req_almostfull) begin
            wr_fence_valid <= 1'b1;
            state          <= WR_FLAG;
          end
        end

        // flag tells the host how far the output has progressed
        WR_FLAG: begin
          wr_fence_valid <= 1'b0;
          if (!wr_req_almostfull) begin
            wr_req_en <= 1'b1;
            state     <= WR_DATA;
          end
        end

        default: begin
          state <= WR_DATA;
        end
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state == WR_WAIT && pop) begin
      wr_req.data <= dout;
    end
    if (state == WR_WAIT && !wr_req_almostfull) begin
      wr_req.addr <= wr_addr;
    end
    // counter has already stepped past the data line here
    if (state == WR_FLAG && !wr_req_almostfull) begin
      wr_req.addr <= '0;
      wr_req.data <= cacheline_t'(wr_addr);
    end
  end

endmodule

// ==== source/afu_stream_top.sv ====
/*
 * Top level of the cacheline streaming engine: read request
 * control, address counters, response buffer and write
 * request control
 */

module afu_stream_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  afu_stream_pkg::context_t   afu_context,

  // read request channel
  output afu_stream_pkg::rd_req_t    rd_req,
  output logic                       rd_req_en,
  input  logic                       rd_req_almostfull,

  // read response channel
  input  logic                       rd_rsp_valid,
  input  afu_stream_pkg::cacheline_t rd_rsp_data,

  // write request channel
  output afu_stream_pkg::wr_req_t    wr_req,
  output logic                       wr_req_en,
  input  logic                       wr_req_almostfull,
  output logic                       wr_fence_valid,

  output logic                       done
);

  import afu_stream_pkg::*;

  afu_ctx_t   ctx;
  cl_addr_t   rd_addr;
  cl_addr_t   wr_addr;
  logic       data_wr;
  logic       pop;
  logic       fifo_empty;
  cacheline_t fifo_dout;

  read_req_fsm u_read_req_fsm (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .afu_context      (afu_context),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_addr          (rd_addr),
    .wr_addr          (wr_addr),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .ctx              (ctx)
  );

  // only data writes move the output address
  line_counters u_line_counters (
    .clk      (clk),
    .reset    (reset),
    .rd_req_en(rd_req_en),
    .wr_req_en(data_wr),
    .rd_addr  (rd_addr),
    .wr_addr  (wr_addr)
  );

  line_fifo u_line_fifo (
    .clk         (clk),
    .reset       (reset),
    .rd_rsp_valid(rd_rsp_valid),
    .rd_rsp_data (rd_rsp_data),
    .pop         (pop),
    .dout        (fifo_dout),
    .empty       (fifo_empty)
  );

  write_req_fsm u_write_req_fsm (
    .clk              (clk),
    .reset            (reset),
    .ctx              (ctx),
    .wr_req_almostfull(wr_req_almostfull),
    .empty            (fifo_empty),
    .dout             (fifo_dout),
    .wr_addr          (wr_addr),
    .pop              (pop),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .data_wr          (data_wr),
    .wr_fence_valid   (wr_fence_valid),
    .done             (done)
  );

endmodule

// ==== dv/afu_stream_tb.sv ====
/*
 * Testbench for the cacheline streaming engine: clock, reset,
 * host memory model, request monitor, compare tasks,
 * directed tests and a cycle timeout
 */
`include "afu_stream_cfg.svh"

module afu_stream_tb;

  import afu_stream_pkg::*;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RSP_LATENCY = 4;

  logic       clk;
  logic       reset;
  logic       start;
  context_t   afu_context;
  logic       rd_req_almostfull;
  logic       wr_req_almostfull;
  logic       rd_rsp_valid;
  cacheline_t rd_rsp_data;
  rd_req_t    rd_req;
  logic       rd_req_en;
  wr_req_t    wr_req;
  logic       wr_req_en;
  logic       wr_fence_valid;
  logic       done;

  int         seed = 60129;
  int         cyc = 0;
  int         checks = 0;
  int         errors = 0;
  int         reads_seen;
  int         data_seen;
  int         fences_seen;
  int         flags_seen;
  int         wr_phase;
  int         lines_exp;
  cl_addr_t   image_end;
  logic       stall_on = 1'b0;
  logic       prev_rd_af;
  logic       prev_wr_af;
  cl_addr_t   pend_addr[$];
  int         pend_due[$];

  afu_stream_top UUT (
    .clk              (clk),
    .reset            (reset),
    .start            (start),
    .afu_context      (afu_context),
    .rd_req           (rd_req),
    .rd_req_en        (rd_req_en),
    .rd_req_almostfull(rd_req_almostfull),
    .rd_rsp_valid     (rd_rsp_valid),
    .rd_rsp_data      (rd_rsp_data),
    .wr_req           (wr_req),
    .wr_req_en        (wr_req_en),
    .wr_req_almostfull(wr_req_almostfull),
    .wr_fence_valid   (wr_fence_valid),
    .done             (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // host memory answers each read with the address spread over the line
  function automatic cacheline_t line_pattern(cl_addr_t addr);
    return {8{64'(addr)}} ^ {8{64'hA5C3_0F1E_5A3C_F0E1}};
  endfunction

  function automatic context_t make_context(int lines, int out_end);
    context_t c;
    c = '0;
    c[`AFU_IMAGE_END_LSB +: `AFU_ADDR_W] = cl_addr_t'(lines);
    c[`AFU_OUTPUT_END_LSB +: `AFU_ADDR_W] = cl_addr_t'(out_end);
    return c;
  endfunction

  task automatic check_addr(cl_addr_t got, cl_addr_t exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  task automatic check_line(cacheline_t got, cacheline_t exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic check_bit(logic got, logic exp, string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
    end
  endtask

  // response path, inputs change 10 units after the edge
  always @(posedge clk) begin
    cyc++;
    #10;
    if (reset) begin
      pend_addr.delete();
      pend_due.delete();
    end
    if (pend_due.size() > 0 && pend_due[0] == cyc) begin
      rd_rsp_valid <= 1'b1;
      rd_rsp_data  <= line_pattern(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end else begin
      rd_rsp_valid <= 1'b0;
      rd_rsp_data  <= '0;
    end
    if (stall_on) begin
      rd_req_almostfull <= ($random(seed) & 3) == 0;
      wr_req_almostfull <= ($random(seed) & 3) == 0;
    end else begin
      rd_req_almostfull <= 1'b0;
      wr_req_almostfull <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("run timed out after %0d cycles without finishing the tests", cyc);
      $display("Checks failed");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!reset) begin
      if (rd_req_en) begin
        check_bit(prev_rd_af, 1'b0, "read issued while almost full");
        check_addr(rd_req.addr, cl_addr_t'(reads_seen), "read address");
        checks++;
        if (rd_req.addr >= image_end || reads_seen - data_seen >= 8) begin
          errors++;
          $display("CHECK FAILED at %0t: read %0d out of bounds", $time, rd_req.addr);
        end
        pend_addr.push_back(rd_req.addr);
        pend_due.push_back(cyc + RSP_LATENCY);
        reads_seen++;
      end
      if (wr_req_en) begin
        check_bit(prev_wr_af, 1'b0, "write issued while almost full");
        if (wr_phase == 0) begin
          check_addr(wr_req.addr, cl_addr_t'(data_seen + 1), "data write address");
          check_line(wr_req.data, line_pattern(cl_addr_t'(data_seen)), "data write line");
          data_seen++;
          wr_phase = 1;
        end else begin
          check_bit(wr_phase == 2, 1'b1, "flag write before fence");
          check_addr(wr_req.addr, '0, "flag write address");
          check_line(wr_req.data, cacheline_t'(data_seen + 1), "flag write line");
          flags_seen++;
          wr_phase = 0;
        end
      end
      if (wr_fence_valid) begin
        check_bit(prev_wr_af, 1'b0, "fence issued while almost full");
        check_bit(wr_phase == 1, 1'b1, "fence without a data write");
        fences_seen++;
        wr_phase = 2;
      end
      if (done && flags_seen < lines_exp) begin
        check_bit(done, 1'b0, "done before the last flag write");
      end
    end
    prev_rd_af = rd_req_almostfull;
    prev_wr_af = wr_req_almostfull;
  end

  task automatic apply_reset(int lines, int out_end);
    @(posedge clk);
    #10;
    reset       = 1'b1;
    afu_context = make_context(lines, out_end);
    image_end   = cl_addr_t'(lines);
    lines_exp   = lines;
    reads_seen  = 0;
    data_seen   = 0;
    fences_seen = 0;
    flags_seen  = 0;
    wr_phase    = 0;
    repeat (4) @(posedge clk);
    #10;
    reset = 1'b0;
  endtask

  // start pulse, returns the number of edges until the first read
  task automatic pulse_start(output int edges);
    edges = 0;
    @(posedge clk);
    #10;
    start = 1'b1;
    do begin
      @(posedge clk);
      edges++;
      if (edges == 1) begin
        #10;
        start = 1'b0;
      end
      @(negedge clk);
    end while (!rd_req_en && edges < 50);
  endtask

  task automatic run_copy(int lines, int out_end);
    int edges;
    apply_reset(lines, out_end);
    pulse_start(edges);
    while (flags_seen < lines) @(posedge clk);
    @(negedge clk);
    while (!done) @(negedge clk);
    check_addr(cl_addr_t'(reads_seen), cl_addr_t'(lines), "reads issued");
    check_addr(cl_addr_t'(fences_seen), cl_addr_t'(lines), "fences issued");
  endtask

  initial begin
    int edges;
    reset = 1'b1;
    start = 1'b0;
    afu_context = '0;
    rd_req_almostfull = 1'b0;
    wr_req_almostfull = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data = '0;
    image_end = '0;
    lines_exp = 0;

    apply_reset(1, 2);
    @(negedge clk);
    check_bit(rd_req_en, 1'b0, "read strobe after reset");
    check_bit(wr_req_en, 1'b0, "write strobe after reset");
    check_bit(wr_fence_valid, 1'b0, "fence after reset");
    check_bit(done, 1'b0, "done after reset");
    pulse_start(edges);
    check_addr(cl_addr_t'(edges), 3, "edges from start to first read");
    check_addr(rd_req.addr, '0, "first read address");
    while (flags_seen < 1) @(posedge clk);
    $display("test 1 after reset finished, errors %0d", errors);

    run_copy(5, 6);
    $display("test 2 short copy finished, errors %0d", errors);

    run_copy(3, 4);
    check_addr(cl_addr_t'(flags_seen), 3, "flag writes");
    $display("test 3 write sequence finished, errors %0d", errors);

    run_copy(20, 21);
    $display("test 4 batched copy finished, errors %0d", errors);

    stall_on = 1'b1;
    run_copy(20, 21);
    stall_on = 1'b0;
    $display("test 5 back-pressure finished, errors %0d", errors);

    run_copy(5, 6);
    repeat (20) begin
      @(negedge clk);
      check_bit(done, 1'b1, "done held high");
    end
    check_addr(cl_addr_t'(reads_seen), 5, "no reads after done");
    $display("test 6 done finished, errors %0d", errors);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
source/afu_stream_pkg.sv
source/line_counters.sv
source/read_req_fsm.sv
source/line_fifo.sv
source/write_req_fsm.sv
source/afu_stream_top.sv
dv/afu_stream_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= afu_stream_tb
RTL_TOP   ?= afu_stream_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
